// ==== common/cnn_cfg_pkg.sv ====
`default_nettype none

package cnn_cfg_pkg;

    // ==================================================
    // numeric widths
    // ==================================================

    // pixel, unsigned greyscale
    localparam int PIX_W = 8;
    // kernel weight, signed
    localparam int W_W   = 8;
    // per channel bias, signed
    localparam int B_W   = 16;
    // kernel sum of products
    localparam int ACC_W = 21;
    // kernel sum plus bias, one bit of headroom
    localparam int SUM_W = 22;
    // result after relu, unsigned
    localparam int RES_W = 20;

    // upper bounds, fix the stream struct sizes
    localparam int MAX_CO = 8;
    localparam int MAX_KX = 7;
    localparam int MAX_KY = 7;

    // ==================================================
    // vector types
    // ==================================================
    typedef logic        [PIX_W-1:0] pixel_t;
    typedef logic signed [W_W-1:0]   weight_t;
    typedef logic signed [B_W-1:0]   bias_t;
    typedef logic signed [ACC_W-1:0] acc_t;
    typedef logic signed [SUM_W-1:0] sum_t;
    typedef logic        [RES_W-1:0] result_t;

endpackage

`default_nettype wire

// ==== common/cnn_stream_pkg.sv ====
`default_nettype none

package cnn_stream_pkg;

    // window slots at the largest supported kernel
    localparam int MAX_WIN = cnn_cfg_pkg::MAX_KX * cnn_cfg_pkg::MAX_KY;

    // ==================================================
    // window stream, line buffer to kernels
    // ==================================================
    // pix index is ky*KX + kx, top left first
    // slots past KX*KY are zero
    typedef struct packed {
        logic                              valid;
        logic                              step;
        cnn_cfg_pkg::pixel_t [MAX_WIN-1:0] pix;
    } window_beat_t;

    // ==================================================
    // result beat, one field per output channel
    // ==================================================
    // channels above CO are zero
    typedef struct packed {
        cnn_cfg_pkg::result_t [cnn_cfg_pkg::MAX_CO-1:0] ch;
    } result_beat_t;

endpackage

`default_nettype wire

// ==== cnn_core/line_buffer.sv ====
`default_nettype none

module line_buffer #(
    parameter int KX = 3,
    parameter int KY = 3,
    parameter int IX = 8,
    parameter int IY = 6
) (
    input  logic                        clk,
    input  logic                        reset_n,
    input  logic                        i_in_valid,
    input  cnn_cfg_pkg::pixel_t         i_in_pixel,
    output cnn_stream_pkg::window_beat_t o_window
);

    localparam int CW = (IX > 1) ? $clog2(IX) : 1;
    localparam int RW = (IY > 1) ? $clog2(IY) : 1;

    // ==================================================
    // frame position
    // ==================================================
    logic [CW-1:0] col;
    logic [RW-1:0] row;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            col <= '0;
            row <= '0;
        end else if (i_in_valid) begin
            if (col == CW'(IX - 1)) begin
                col <= '0;
                // wrap row at frame end
                row <= (row == RW'(IY - 1)) ? '0 : row + 1'b1;
            end else begin
                col <= col + 1'b1;
            end
        end
    end

    // ==================================================
    // row memories
    // ==================================================
    // row_mem[0] holds the previous row, row_mem[1] the one above
    cnn_cfg_pkg::pixel_t row_mem [KY-1][IX];
    // column entering the window, bottom is the new pixel
    cnn_cfg_pkg::pixel_t col_new [KY];

    always_comb begin
        col_new[KY-1] = i_in_pixel;
        for (int k = 0; k < KY - 1; k++) begin
            col_new[KY-2-k] = row_mem[k][col];
        end
    end

    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            row_mem[0][col] <= i_in_pixel;
            // older rows move up one memory
            for (int k = 1; k < KY - 1; k++) begin
                row_mem[k][col] <= row_mem[k-1][col];
            end
        end
    end

    // ==================================================
    // shift window
    // ==================================================
    cnn_cfg_pkg::pixel_t win [KY][KX];
    logic                win_valid;
    logic                win_step;

    always_ff @(posedge clk) begin
        if (i_in_valid) begin
            for (int ky = 0; ky < KY; ky++) begin
                for (int kx = 0; kx < KX - 1; kx++) begin
                    win[ky][kx] <= win[ky][kx+1];
                end
                win[ky][KX-1] <= col_new[ky];
            end
        end
    end

    // full window once enough columns and rows have been seen
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            win_valid <= 1'b0;
            win_step  <= 1'b0;
        end else begin
            win_valid <= i_in_valid && (col >= CW'(KX - 1)) && (row >= RW'(KY - 1));
            win_step  <= i_in_valid;
        end
    end

    // flatten into the stream struct
    always_comb begin
        o_window       = '0;
        o_window.valid = win_valid;
        o_window.step  = win_step;
        for (int ky = 0; ky < KY; ky++) begin
            for (int kx = 0; kx < KX; kx++) begin
                o_window.pix[ky*KX+kx] = win[ky][kx];
            end
        end
    end

endmodule

`default_nettype wire

// ==== cnn_core/cnn_kernel.sv ====
`default_nettype none

module cnn_kernel #(
    parameter int KX = 3,
    parameter int KY = 3
) (
    input  logic                               clk,
    input  logic                               reset_n,
    input  cnn_cfg_pkg::weight_t [KX*KY-1:0]   i_weight,
    input  cnn_stream_pkg::window_beat_t       i_window,
    output logic                               o_acc_valid,
    output cnn_cfg_pkg::acc_t                  o_acc
);

    localparam int NTAP = KX * KY;
    // zero extended pixel times signed weight
    localparam int PROD_W = cnn_cfg_pkg::PIX_W + 1 + cnn_cfg_pkg::W_W;

    // ==================================================
    // valid pipeline
    // ==================================================
    logic prod_valid;
    logic acc_valid;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            prod_valid <= 1'b0;
            acc_valid  <= 1'b0;
        end else begin
            // only full windows enter
            prod_valid <= i_window.valid;
            acc_valid  <= prod_valid;
        end
    end

    // ==================================================
    // stage one, products
    // ==================================================
    logic signed [PROD_W-1:0] prod [NTAP];

    always_ff @(posedge clk) begin
        if (i_window.valid) begin
            for (int i = 0; i < NTAP; i++) begin
                // pixel is unsigned, so a leading zero keeps it positive
                prod[i] <= $signed({1'b0, i_window.pix[i]}) * i_weight[i];
            end
        end
    end

    // ==================================================
    // stage two, sum of products
    // ==================================================
    cnn_cfg_pkg::acc_t sum_d;
    cnn_cfg_pkg::acc_t sum_q;

    always_comb begin
        sum_d = '0;
        for (int i = 0; i < NTAP; i++) begin
            // sign extend each product to the accumulator
            sum_d = sum_d + cnn_cfg_pkg::acc_t'(prod[i]);
        end
    end

    always_ff @(posedge clk) begin
        if (prod_valid) begin
            sum_q <= sum_d;
        end
    end

    assign o_acc_valid = acc_valid;
    assign o_acc       = sum_q;

endmodule

`default_nettype wire

// ==== cnn_core/bias_relu.sv ====
`default_nettype none

module bias_relu #(
    parameter int CO = 3
) (
    input  logic                          clk,
    input  logic                          reset_n,
    input  cnn_cfg_pkg::bias_t [CO-1:0]   i_bias,
    input  logic [CO-1:0]                 i_acc_valid,
    input  cnn_cfg_pkg::acc_t [CO-1:0]    i_acc,
    output logic                          o_res_valid,
    output cnn_stream_pkg::result_beat_t  o_res
);

    // largest result, zero extended into the sum width
    localparam cnn_cfg_pkg::sum_t RES_MAX =
        cnn_cfg_pkg::sum_t'({cnn_cfg_pkg::RES_W{1'b1}});

    // ==================================================
    // bias add, relu, saturate
    // ==================================================
    cnn_cfg_pkg::sum_t            sum [CO];
    cnn_stream_pkg::result_beat_t res_d;

    always_comb begin
        res_d = '0;
        for (int c = 0; c < CO; c++) begin
            sum[c] = cnn_cfg_pkg::sum_t'($signed(i_acc[c]))
                   + cnn_cfg_pkg::sum_t'($signed(i_bias[c]));
            // negative clips to zero, overflow to all ones
            if (sum[c] < 0) begin
                res_d.ch[c] = '0;
            end else if (sum[c] > RES_MAX) begin
                res_d.ch[c] = '1;
            end else begin
                res_d.ch[c] = sum[c][cnn_cfg_pkg::RES_W-1:0];
            end
        end
    end

    // all kernels run in lockstep
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            o_res_valid <= 1'b0;
        end else begin
            o_res_valid <= &i_acc_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (&i_acc_valid) begin
            o_res <= res_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/credit_out_queue.sv ====
`default_nettype none

module credit_out_queue #(
    parameter int OUT_DEPTH = 4
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         i_step,
    input  logic                         i_no_window,
    input  logic                         i_res_valid,
    input  cnn_stream_pkg::result_beat_t i_res,
    input  logic                         i_ot_credit,
    output logic                         o_in_credit,
    output logic                         o_ot_valid,
    output cnn_stream_pkg::result_beat_t o_ot_beat
);

    localparam int PTR_W = (OUT_DEPTH > 1) ? $clog2(OUT_DEPTH) : 1;
    localparam int CNT_W = $clog2(OUT_DEPTH + 1);
    // sink may hand out more credits than the queue holds
    localparam int OC_W  = 16;

    // ==================================================
    // result FIFO
    // ==================================================
    cnn_stream_pkg::result_beat_t mem [OUT_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign push = i_res_valid;
    // a beat leaves whenever one is shown
    assign pop  = o_ot_valid;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_res;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(OUT_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    // ==================================================
    // input credits
    // ==================================================
    // reserved counts slots promised to the pixel source
    logic [CNT_W-1:0] reserved;
    logic             issue;
    logic             skip;

    assign issue = (reserved < CNT_W'(OUT_DEPTH));
    // pixel gave no window, its slot comes back now
    assign skip  = i_step & i_no_window;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            reserved    <= '0;
            o_in_credit <= 1'b0;
        end else begin
            reserved    <= reserved + CNT_W'(issue) - CNT_W'(pop) - CNT_W'(skip);
            o_in_credit <= issue;
        end
    end

    // ==================================================
    // output credits
    // ==================================================
    logic [OC_W-1:0] ot_cred;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ot_cred <= '0;
        end else begin
            ot_cred <= ot_cred + OC_W'(i_ot_credit) - OC_W'(pop);
        end
    end

    assign o_ot_valid = (count != '0) && (ot_cred != '0);
    assign o_ot_beat  = mem[rd_ptr];

endmodule

`default_nettype wire

// ==== rtl/cnn_core_top.sv ====
`default_nettype none

module cnn_core_top #(
    parameter int KX        = 3,
    parameter int KY        = 3,
    parameter int IX        = 8,
    parameter int IY        = 6,
    parameter int CO        = 3,
    parameter int OUT_DEPTH = 4
) (
    input  logic                                clk,
    input  logic                                reset_n,
    input  cnn_cfg_pkg::weight_t [CO*KX*KY-1:0] i_weight,
    input  cnn_cfg_pkg::bias_t [CO-1:0]         i_bias,
    input  logic                                i_in_valid,
    input  cnn_cfg_pkg::pixel_t                 i_in_pixel,
    input  logic                                i_ot_credit,
    output logic                                o_in_credit,
    output logic                                o_ot_valid,
    output cnn_stream_pkg::result_beat_t        o_ot_beat
);

    cnn_stream_pkg::window_beat_t w_window;
    logic [CO-1:0]                w_acc_valid;
    cnn_cfg_pkg::acc_t [CO-1:0]   w_acc;
    logic                         w_res_valid;
    cnn_stream_pkg::result_beat_t w_res;

    // ==================================================
    // window assembly
    // ==================================================
    line_buffer #(.KX(KX), .KY(KY), .IX(IX), .IY(IY)) u_line_buffer (
        .clk        (clk),
        .reset_n    (reset_n),
        .i_in_valid (i_in_valid),
        .i_in_pixel (i_in_pixel),
        .o_window   (w_window)
    );

    // ==================================================
    // one kernel per output channel
    // ==================================================
    for (genvar c = 0; c < CO; c++) begin : gen_kernel
        cnn_kernel #(.KX(KX), .KY(KY)) u_cnn_kernel (
            .clk         (clk),
            .reset_n     (reset_n),
            .i_weight    (i_weight[c*KX*KY +: KX*KY]),
            .i_window    (w_window),
            .o_acc_valid (w_acc_valid[c]),
            .o_acc       (w_acc[c])
        );
    end

    // bias, relu, saturation
    bias_relu #(.CO(CO)) u_bias_relu (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_bias      (i_bias),
        .i_acc_valid (w_acc_valid),
        .i_acc       (w_acc),
        .o_res_valid (w_res_valid),
        .o_res       (w_res)
    );

    // ==================================================
    // result queue and credit flow
    // ==================================================
    credit_out_queue #(.OUT_DEPTH(OUT_DEPTH)) u_credit_out_queue (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_step      (w_window.step),
        .i_no_window (~w_window.valid),
        .i_res_valid (w_res_valid),
        .i_res       (w_res),
        .i_ot_credit (i_ot_credit),
        .o_in_credit (o_in_credit),
        .o_ot_valid  (o_ot_valid),
        .o_ot_beat   (o_ot_beat)
    );

endmodule

`default_nettype wire

// ==== sim/cnn_ref_model.svh ====
`ifndef CNN_REF_MODEL_SVH
`define CNN_REF_MODEL_SVH

// ==================================================
// reference model, valid convolution, stride 1
// ==================================================
// reads frm, wgt and bia of the enclosing testbench
// weight tap index is ky*KX + kx, top left first

// weighted window sum, one channel, window top left at (ox, oy)
function automatic int window_sum(input int f, input int c, input int ox, input int oy);
    int s;
    s = 0;
    for (int ky = 0; ky < KY; ky++) begin
        for (int kx = 0; kx < KX; kx++) begin
            // pixel unsigned, weight signed
            s += int'(frm[f][oy+ky][ox+kx]) * int'($signed(wgt[f][c*KX*KY + ky*KX + kx]));
        end
    end
    return s;
endfunction

// relu then clamp to the result range
function automatic cnn_cfg_pkg::result_t relu_sat(input int s);
    int top;
    top = (1 << cnn_cfg_pkg::RES_W) - 1;
    if (s < 0) begin
        return '0;
    end else if (s > top) begin
        return '1;
    end
    return cnn_cfg_pkg::result_t'(s);
endfunction

// full beat for output number idx of frame f, raster order
function automatic cnn_stream_pkg::result_beat_t expected_beat(input int f, input int idx);
    cnn_stream_pkg::result_beat_t b;
    int ox;
    int oy;
    b  = '0;
    ox = idx % OX;
    oy = idx / OX;
    for (int c = 0; c < CO; c++) begin
        b.ch[c] = relu_sat(window_sum(f, c, ox, oy) + int'($signed(bia[f][c])));
    end
    return b;
endfunction

`endif

// ==== sim/tb_cnn_core.sv ====
`default_nettype none

module tb_cnn_core;

    localparam int KX        = 3;
    localparam int KY        = 3;
    localparam int IX        = 8;
    localparam int IY        = 6;
    localparam int CO        = 3;
    localparam int OUT_DEPTH = 4;
    localparam int NTAP      = CO * KX * KY;
    // frames: plain, negative bias, large weights
    localparam int NF        = 3;
    localparam int OX        = IX - KX + 1;
    localparam int OY        = IY - KY + 1;
    localparam int NBEAT     = OX * OY;
    localparam int TIMEOUT   = 1000;

    logic                            clk = 1'b0;
    logic                            reset_n;
    cnn_cfg_pkg::weight_t [NTAP-1:0] i_weight;
    cnn_cfg_pkg::bias_t [CO-1:0]     i_bias;
    logic                            i_in_valid;
    cnn_cfg_pkg::pixel_t             i_in_pixel;
    logic                            i_ot_credit;
    logic                            o_in_credit;
    logic                            o_ot_valid;
    cnn_stream_pkg::result_beat_t    o_ot_beat;

    // stored stimulus, one set per frame
    cnn_cfg_pkg::pixel_t             frm [NF][IY][IX];
    cnn_cfg_pkg::weight_t [NTAP-1:0] wgt [NF];
    cnn_cfg_pkg::bias_t [CO-1:0]     bia [NF];

    `include "cnn_ref_model.svh"

    // ==================================================
    // scoreboard state
    // ==================================================
    int          val_errors   = 0;
    int          prot_errors  = 0;
    int          timeouts     = 0;
    int          beat_count   = 0;
    int          ot_returned  = 0;
    int          in_issued    = 0;
    int          in_sent      = 0;
    int          src_credits  = 0;
    int          zero_fields  = 0;
    int          pause_left   = 0;
    int          paused_frame = -1;
    logic        after_reset  = 1'b0;
    logic [31:0] rng;

    cnn_core_top #(
        .KX(KX), .KY(KY), .IX(IX), .IY(IY), .CO(CO), .OUT_DEPTH(OUT_DEPTH)
    ) UUT (
        .clk         (clk),
        .reset_n     (reset_n),
        .i_weight    (i_weight),
        .i_bias      (i_bias),
        .i_in_valid  (i_in_valid),
        .i_in_pixel  (i_in_pixel),
        .i_ot_credit (i_ot_credit),
        .o_in_credit (o_in_credit),
        .o_ot_valid  (o_ot_valid),
        .o_ot_beat   (o_ot_beat)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift32(rng);
        return rng;
    endfunction

    // a wait ran out, later waits are skipped
    task automatic report_timeout(input string why);
        $display("Timeout: %s", why);
        timeouts++;
    endtask

    // frames, weights and biases for the whole run
    task automatic make_stimulus();
        logic [31:0] r;
        for (int f = 0; f < NF; f++) begin
            for (int y = 0; y < IY; y++) begin
                for (int x = 0; x < IX; x++) begin
                    r = next_rand();
                    frm[f][y][x] = r[7:0];
                end
            end
            for (int i = 0; i < NTAP; i++) begin
                r = next_rand();
                // frame 2, weights 96 to 127
                wgt[f][i] = (f == 2) ? cnn_cfg_pkg::weight_t'(8'd96 + r[4:0])
                                     : cnn_cfg_pkg::weight_t'(r[7:0]);
            end
            for (int c = 0; c < CO; c++) begin
                r = next_rand();
                // frame 1, bias near the negative limit
                bia[f][c] = (f == 1) ? cnn_cfg_pkg::bias_t'(16'h8000 + r[9:0])
                                     : cnn_cfg_pkg::bias_t'($signed(r[11:0]));
            end
        end
    endtask

    // one pixel under input credit, called on a rising edge
    task automatic send_pixel(input cnn_cfg_pkg::pixel_t pix);
        int waited;
        waited = 0;
        while (src_credits == 0 && waited < TIMEOUT) begin
            i_in_valid <= 1'b0;
            @(posedge clk);
            waited++;
        end
        if (src_credits == 0) begin
            report_timeout("no input credit arrived");
        end else begin
            i_in_valid <= 1'b1;
            i_in_pixel <= pix;
            src_credits--;
            @(posedge clk);
        end
    endtask

    // load coefficients, stream the frame, wait for all its beats
    task automatic run_frame(input int f);
        int waited;
        @(posedge clk);
        i_weight <= wgt[f];
        i_bias   <= bia[f];
        for (int y = 0; y < IY; y++) begin
            for (int x = 0; x < IX; x++) begin
                if (timeouts == 0) begin
                    send_pixel(frm[f][y][x]);
                end
            end
        end
        i_in_valid <= 1'b0;
        waited = 0;
        while (timeouts == 0 && beat_count < (f + 1) * NBEAT && waited < TIMEOUT) begin
            @(posedge clk);
            waited++;
        end
        if (timeouts == 0 && beat_count < (f + 1) * NBEAT) begin
            report_timeout("frame beats did not all arrive");
        end
    endtask

    // ==================================================
    // sink, random credits, one long pause per frame
    // ==================================================
    always @(posedge clk) begin : sink
        logic [31:0] r;
        if (!reset_n) begin
            i_ot_credit <= 1'b0;
        end else if (pause_left > 0) begin
            i_ot_credit <= 1'b0;
            pause_left--;
        end else if ((beat_count % NBEAT == NBEAT / 2)
                     && (beat_count / NBEAT != paused_frame)) begin
            paused_frame = beat_count / NBEAT;
            pause_left   = 3 * NBEAT;
            i_ot_credit <= 1'b0;
        end else begin
            r = next_rand();
            // at most two credits outstanding, so the pause backs up the queue
            i_ot_credit <= r[0] && (ot_returned - beat_count < 2);
        end
    end

    // ==================================================
    // monitor, sampled on the falling edge
    // ==================================================
    always @(negedge clk) begin : monitor
        cnn_stream_pkg::result_beat_t exp_beat;
        if (!reset_n || after_reset) begin
            assert (!o_ot_valid && !o_in_credit) else begin
                prot_errors++;
                $display("Error: around reset o_ot_valid=%h o_in_credit=%h",
                         o_ot_valid, o_in_credit);
            end
        end
        after_reset = !reset_n;
        // pixel must use a credit granted in an earlier cycle
        if (i_in_valid) begin
            assert (in_issued > in_sent) else begin
                prot_errors++;
                $display("pixel sent without an input credit");
            end
            in_sent++;
        end
        // input credit ledger
        if (o_in_credit) begin
            in_issued++;
            src_credits++;
        end
        assert (in_issued - in_sent <= OUT_DEPTH) else begin
            prot_errors++;
            $display("more than %0d input credits outstanding", OUT_DEPTH);
        end
        // output beats against sink credits
        if (o_ot_valid) begin
            assert (beat_count < ot_returned) else begin
                prot_errors++;
                $display("beat sent without an output credit");
            end
            if (beat_count >= NF * NBEAT) begin
                prot_errors++;
                $display("extra beat after the last frame");
            end else begin
                exp_beat = expected_beat(beat_count / NBEAT, beat_count % NBEAT);
                for (int c = 0; c < cnn_cfg_pkg::MAX_CO; c++) begin
                    assert (o_ot_beat.ch[c] == exp_beat.ch[c]) else begin
                        val_errors++;
                        $display("Error: o_ot_beat.ch[%0d] beat %0d expected %h got %h",
                                 c, beat_count, exp_beat.ch[c], o_ot_beat.ch[c]);
                    end
                    if (beat_count / NBEAT == 1 && c < CO && o_ot_beat.ch[c] == '0) begin
                        zero_fields++;
                    end
                end
            end
            beat_count++;
        end
        // credit counts once the core samples it
        if (i_ot_credit) begin
            ot_returned++;
        end
    end

    // ==================================================
    // main sequence
    // ==================================================
    initial begin : stimulus
        reset_n     = 1'b0;
        i_weight    = '0;
        i_bias      = '0;
        i_in_valid  = 1'b0;
        i_in_pixel  = '0;
        i_ot_credit = 1'b0;
        rng         = 32'd53247;
        make_stimulus();
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
        for (int f = 0; f < NF; f++) begin
            if (timeouts == 0) begin
                run_frame(f);
            end
        end
        if (timeouts == 0) begin
            // quiet period, nothing more may come out
            repeat (4 * NBEAT) @(posedge clk);
            assert (beat_count == NF * NBEAT) else begin
                prot_errors++;
                $display("got %0d beats in total instead of %0d", beat_count, NF * NBEAT);
            end
            assert (zero_fields > 0) else begin
                prot_errors++;
                $display("negative bias frame produced no zero result");
            end
        end
        $display("errors: %0d value, %0d protocol, %0d timeout, %0d beats checked",
                 val_errors, prot_errors, timeouts, beat_count);
        if (val_errors + prot_errors + timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== cnn_core_top.f ====
+incdir+sim
common/cnn_cfg_pkg.sv
common/cnn_stream_pkg.sv
cnn_core/line_buffer.sv
cnn_core/cnn_kernel.sv
cnn_core/bias_relu.sv
rtl/credit_out_queue.sv
rtl/cnn_core_top.sv
sim/tb_cnn_core.sv

// ==== Makefile ====
# Verilator flow for the convolution core
FLIST = cnn_core_top.f
LOG   = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall -f $(FLIST) --top-module cnn_core_top

sim:
	verilator --binary --assert -Wno-fatal -j 0 -f $(FLIST) --top-module tb_cnn_core -Mdir obj_dir -o tb_cnn_core
	./obj_dir/tb_cnn_core > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF '*** FAILED ***' $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -qF '*** PASSED ***' $(LOG); then \
		echo "simulation did not complete, see $(LOG)"; exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir $(LOG)
